// ==== hdl/core_defines.svh ====
// width and reset constants for the execution core
// data path, program counter and register file sizes

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// register and ALU data width
`define CORE_DATA_W 8

// program counter width
`define CORE_PC_W 16

// pc value after reset
`define CORE_PC_RESET 16'h0200

// A, X, Y, S
`define CORE_NUM_REGS 4

`endif

// ==== hdl/core_pkg.sv ====
// shared types for the execution core
// opcodes, register index, status flag positions, instruction and retire records

`include "core_defines.svh"

package core_pkg;

  typedef enum logic [3:0] {
    OP_ADC = 4'd0,
    OP_SBC = 4'd1,
    OP_AND = 4'd2,
    OP_ORA = 4'd3,
    OP_EOR = 4'd4,
    OP_INC = 4'd5,
    OP_DEC = 4'd6,
    OP_LDI = 4'd7,
    OP_TRN = 4'd8,
    OP_BRC = 4'd9
  } opcode_e;

  // 0 = A, 1 = X, 2 = Y, 3 = S
  typedef logic [1:0] reg_idx_t;

  // bit positions in P
  localparam int FLAG_N = 7;
  localparam int FLAG_V = 6;
  localparam int FLAG_Z = 1;
  localparam int FLAG_C = 0;

  // bits of P that exist, the rest read as zero
  localparam logic [`CORE_DATA_W-1:0] P_MASK = 8'hc3;

  typedef struct packed {
    opcode_e                 op;
    reg_idx_t                dst;
    reg_idx_t                src;
    logic                    use_imm;
    logic [`CORE_DATA_W-1:0] imm;
    logic [`CORE_DATA_W-1:0] br_mask;
    logic                    br_pol;
  } instr_t;

  typedef struct packed {
    logic [`CORE_DATA_W-1:0] result;
    logic [`CORE_DATA_W-1:0] flags;
    logic                    we;
  } alu_out_t;

  typedef struct packed {
    opcode_e                 op;
    reg_idx_t                dst;
    logic [`CORE_DATA_W-1:0] value;
    logic [`CORE_DATA_W-1:0] status;
    logic [`CORE_PC_W-1:0]   pc;
    logic                    taken;
  } retire_t;

endpackage

// ==== hdl/reg_file.sv ====
// register file for A, X, Y and S
// two combinational read ports, one synchronous write port

`timescale 1ns/1ns

`include "core_defines.svh"

module reg_file import core_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  reg_idx_t                rd_a,
  input  reg_idx_t                rd_b,
  input  logic                    wr_en,
  input  reg_idx_t                wr_idx,
  input  logic [`CORE_DATA_W-1:0] wr_data,
  output logic [`CORE_DATA_W-1:0] rd_data_a,
  output logic [`CORE_DATA_W-1:0] rd_data_b
);

  logic [`CORE_DATA_W-1:0] regs [`CORE_NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // reads see the old value in the write cycle
  assign rd_data_a = regs[rd_a];
  assign rd_data_b = regs[rd_b];

endmodule

// ==== hdl/alu.sv ====
// 8-bit ALU for the execution core
// one shared adder for ADC, SBC, INC and DEC, plus logic ops and pass-through
// produces the result, the next flags and the register write-enable

`timescale 1ns/1ns

`include "core_defines.svh"

module alu import core_pkg::*; (
  input  opcode_e                 op,
  input  logic [`CORE_DATA_W-1:0] a,
  input  logic [`CORE_DATA_W-1:0] b,
  input  logic                    carry_in,
  input  logic [`CORE_DATA_W-1:0] flags_in,
  output alu_out_t                out
);

  logic [`CORE_DATA_W-1:0] addend;
  logic                    add_cin;
  logic [`CORE_DATA_W:0]   sum;
  logic [`CORE_DATA_W-1:0] result;
  logic [`CORE_DATA_W-1:0] flags;

  // adder input selection
  always_comb begin
    addend  = b;
    add_cin = carry_in;
    case (op)
      OP_SBC: addend = ~b;
      OP_INC: begin
        addend  = 8'h01;
        add_cin = 1'b0;
      end
      OP_DEC: begin
        addend  = 8'hff;
        add_cin = 1'b0;
      end
      default: ;
    endcase
  end

  assign sum = {1'b0, a} + {1'b0, addend} + {{`CORE_DATA_W{1'b0}}, add_cin};

  always_comb begin
    case (op)
      OP_ADC, OP_SBC, OP_INC, OP_DEC: result = sum[`CORE_DATA_W-1:0];
      OP_AND:                         result = a & b;
      OP_ORA:                         result = a | b;
      OP_EOR:                         result = a ^ b;
      OP_LDI, OP_TRN:                 result = b;
      default:                        result = '0;
    endcase
  end

  // untouched flags pass through, so BRC leaves P as it was
  always_comb begin
    flags = flags_in;
    if (op != OP_BRC) begin
      flags[FLAG_N] = result[`CORE_DATA_W-1];
      flags[FLAG_Z] = (result == '0);
    end
    if (op == OP_ADC || op == OP_SBC) begin
      flags[FLAG_C] = sum[`CORE_DATA_W];
      // signed overflow against the effective second operand
      flags[FLAG_V] = (a[`CORE_DATA_W-1] == addend[`CORE_DATA_W-1]) &&
                      (sum[`CORE_DATA_W-1] != a[`CORE_DATA_W-1]);
    end
  end

  assign out.result = result;
  assign out.flags  = flags;
  assign out.we     = (op != OP_BRC);

endmodule

// ==== hdl/status_unit.sv ====
// processor status register P
// flag update on retire and the mask-and-polarity branch rule

`timescale 1ns/1ns

`include "core_defines.svh"

module status_unit import core_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flag_we,
  input  logic [`CORE_DATA_W-1:0] flags_next,
  input  logic [`CORE_DATA_W-1:0] br_mask,
  input  logic                    br_pol,
  output logic [`CORE_DATA_W-1:0] p,
  output logic                    branch_taken
);

  logic flag_hit;

  always_ff @(posedge clk) begin
    if (reset) begin
      p <= '0;
    end else if (flag_we) begin
      // only N, V, Z and C are stored
      p <= flags_next & P_MASK;
    end
  end

  // any selected flag set, then flipped by the polarity bit
  assign flag_hit     = |(br_mask & p);
  assign branch_taken = br_pol ^ flag_hit;

endmodule

// ==== hdl/pc_unit.sv ====
// 16-bit program counter
// steps by one, or by one plus a signed 8-bit offset on a taken branch

`timescale 1ns/1ns

`include "core_defines.svh"

module pc_unit (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    step,
  input  logic                    taken,
  input  logic [`CORE_DATA_W-1:0] offset,
  output logic [`CORE_PC_W-1:0]   pc,
  output logic [`CORE_PC_W-1:0]   pc_next
);

  localparam logic [`CORE_PC_W-1:0] PC_ONE = {{(`CORE_PC_W-1){1'b0}}, 1'b1};

  logic [`CORE_PC_W-1:0] offset_ext;
  logic [`CORE_PC_W-1:0] pc_inc;

  assign offset_ext = {{(`CORE_PC_W-`CORE_DATA_W){offset[`CORE_DATA_W-1]}}, offset};
  assign pc_inc     = pc + PC_ONE;

  // wraps modulo 2^16
  assign pc_next = taken ? pc_inc + offset_ext : pc_inc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `CORE_PC_RESET;
    end else if (step) begin
      pc <= pc_next;
    end
  end

endmodule

// ==== hdl/exec_control.sv ====
// instruction sequencer for the execution core
// IDLE -> READ -> EXEC, holds the accepted instruction and strobes retire

`timescale 1ns/1ns

module exec_control import core_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   instr_valid,
  input  instr_t instr,
  output logic   busy,
  output instr_t cur_instr,
  output logic   do_retire,
  output logic   retire_valid
);

  typedef enum logic [1:0] {
    IDLE,
    READ,
    EXEC
  } state_e;

  state_e state;
  state_e state_next;
  logic   accept;

  // strobes arriving while busy are dropped
  assign accept = instr_valid & ~busy;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_next = READ;
        end
      end
      READ:    state_next = EXEC;
      EXEC:    state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // instruction stays put until the next accept
  always_ff @(posedge clk) begin
    if (reset) begin
      cur_instr <= '0;
    end else if (accept) begin
      cur_instr <= instr;
    end
  end

  // one cycle late, so the reported state is already written
  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= do_retire;
    end
  end

  assign do_retire = (state == EXEC);

  // stays high through the retire_valid cycle
  assign busy = (state != IDLE) | retire_valid;

endmodule

// ==== hdl/exec_core.sv ====
// top level of the execution core
// connects sequencer, register file, ALU, status register and PC
// and captures the retire record

`timescale 1ns/1ns

`include "core_defines.svh"

module exec_core import core_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    instr_valid,
  input  instr_t                  instr,
  output logic                    busy,
  output logic                    retire_valid,
  output retire_t                 retire,
  output logic [`CORE_DATA_W-1:0] status
);

  instr_t                  cur_instr;
  logic                    do_retire;
  logic [`CORE_DATA_W-1:0] rd_data_a;
  logic [`CORE_DATA_W-1:0] rd_data_b;
  logic [`CORE_DATA_W-1:0] operand_b;
  alu_out_t                alu_out;
  logic                    branch_taken;
  logic                    taken;
  logic                    commit;
  logic [`CORE_PC_W-1:0]   pc_next;

  exec_control u_control (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .busy         (busy),
    .cur_instr    (cur_instr),
    .do_retire    (do_retire),
    .retire_valid (retire_valid)
  );

  // dst is also the first operand, LDI always takes the immediate
  assign operand_b = (cur_instr.use_imm || cur_instr.op == OP_LDI) ? cur_instr.imm
                                                                   : rd_data_b;

  reg_file u_regs (
    .clk       (clk),
    .reset     (reset),
    .rd_a      (cur_instr.dst),
    .rd_b      (cur_instr.src),
    .wr_en     (commit),
    .wr_idx    (cur_instr.dst),
    .wr_data   (alu_out.result),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

  alu u_alu (
    .op       (cur_instr.op),
    .a        (rd_data_a),
    .b        (operand_b),
    .carry_in (status[FLAG_C]),
    .flags_in (status),
    .out      (alu_out)
  );

  // register and flag writes share the ALU write-enable
  assign commit = do_retire & alu_out.we;
  assign taken  = branch_taken & (cur_instr.op == OP_BRC);

  status_unit u_status (
    .clk          (clk),
    .reset        (reset),
    .flag_we      (commit),
    .flags_next   (alu_out.flags),
    .br_mask      (cur_instr.br_mask),
    .br_pol       (cur_instr.br_pol),
    .p            (status),
    .branch_taken (branch_taken)
  );

  pc_unit u_pc (
    .clk     (clk),
    .reset   (reset),
    .step    (do_retire),
    .taken   (taken),
    .offset  (cur_instr.imm),
    .pc      (),
    .pc_next (pc_next)
  );

  // alu flags already equal the next P, BRC passes P through
  always_ff @(posedge clk) begin
    if (reset) begin
      retire <= '0;
    end else if (do_retire) begin
      retire.op     <= cur_instr.op;
      retire.dst    <= cur_instr.dst;
      retire.value  <= alu_out.result;
      retire.status <= alu_out.flags & P_MASK;
      retire.pc     <= pc_next;
      retire.taken  <= taken;
    end
  end

endmodule

// ==== test/exec_core_properties.sv ====
// handshake timing checks for the execution core
// bound into exec_core from the testbench

`timescale 1ns/1ns

module exec_core_properties (
  input logic clk,
  input logic reset,
  input logic instr_valid,
  input logic busy,
  input logic retire_valid
);

  int failures = 0;

  // retire is a one-cycle strobe
  retire_single : assert property (
    @(posedge clk) disable iff (reset) retire_valid |=> !retire_valid
  ) else begin
    $error("retire_valid high on two consecutive clocks");
    failures++;
  end

  // accepted on edge T, retire_valid rises on edge T+2 and is sampled high on T+3
  retire_after_accept : assert property (
    @(posedge clk) disable iff (reset)
      (instr_valid && !busy) |=> !retire_valid ##1 !retire_valid ##1 retire_valid
  ) else begin
    $error("retire_valid not seen two clocks after acceptance");
    failures++;
  end

  busy_after_reset : assert property (
    @(posedge clk) reset |=> !busy
  ) else begin
    $error("busy high after reset");
    failures++;
  end

endmodule

// ==== test/exec_core_tb.sv ====
// testbench for the execution core
// random decoded instructions, reference model and retire comparison

`timescale 1ns/1ns

`include "core_defines.svh"

module exec_core_tb import core_pkg::*; ();

  localparam int WAIT_LIMIT = 20;

  logic                    clk;
  logic                    reset;
  logic                    instr_valid;
  instr_t                  instr;
  logic                    busy;
  logic                    retire_valid;
  retire_t                 retire;
  logic [`CORE_DATA_W-1:0] status;

  logic [31:0]             rng_state;
  logic [`CORE_DATA_W-1:0] m_regs [`CORE_NUM_REGS];
  logic [`CORE_DATA_W-1:0] m_p;
  logic [`CORE_PC_W-1:0]   m_pc;
  retire_t                 exp_q [$];
  int value_errors;
  int status_errors;
  int other_errors;
  int issued;
  int retired;

  exec_core DUT (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .busy         (busy),
    .retire_valid (retire_valid),
    .retire       (retire),
    .status       (status)
  );

  bind exec_core exec_core_properties u_props (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .busy         (busy),
    .retire_valid (retire_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // branch fields are random for every op
  function automatic instr_t build_instr(input opcode_e op, input reg_idx_t dst,
                                         input reg_idx_t src, input logic use_imm,
                                         input logic [7:0] imm);
    instr_t      ins;
    logic [31:0] r;
    r           = next_random();
    ins.op      = op;
    ins.dst     = dst;
    ins.src     = src;
    ins.use_imm = use_imm;
    ins.imm     = imm;
    ins.br_mask = r[7:0];
    ins.br_pol  = r[8];
    return ins;
  endfunction

  // architectural model: registers, P and pc
  function automatic retire_t model_step(input instr_t ins);
    retire_t    r;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] res;
    logic       c;
    logic       v;
    int         s;
    a   = m_regs[ins.dst];
    b   = (ins.use_imm || ins.op == OP_LDI) ? ins.imm : m_regs[ins.src];
    c   = m_p[FLAG_C];
    v   = m_p[FLAG_V];
    res = 8'h00;
    case (ins.op)
      OP_ADC: begin
        s   = int'(a) + int'(b) + int'(c);
        res = s[7:0];
        c   = (s > 255);
        v   = (a[7] == b[7]) && (res[7] != a[7]);
      end
      OP_SBC: begin
        s   = int'(a) + 255 - int'(b) + int'(c);
        res = s[7:0];
        c   = (s > 255);
        v   = (a[7] != b[7]) && (res[7] != a[7]);
      end
      OP_AND:         res = a & b;
      OP_ORA:         res = a | b;
      OP_EOR:         res = a ^ b;
      OP_INC:         res = a + 8'd1;
      OP_DEC:         res = a - 8'd1;
      OP_LDI, OP_TRN: res = b;
      default:        res = 8'h00;
    endcase
    r.taken = (ins.op == OP_BRC) && (((ins.br_mask & m_p) != 8'h00) != ins.br_pol);
    if (ins.op != OP_BRC) begin
      m_regs[ins.dst] = res;
      // N V - - - - Z C
      m_p = {res[7], v, 4'b0000, (res == 8'h00), c};
    end
    m_pc     = m_pc + 16'd1 + (r.taken ? {{8{ins.imm[7]}}, ins.imm} : 16'd0);
    r.op     = ins.op;
    r.dst    = ins.dst;
    r.value  = res;
    r.status = m_p;
    r.pc     = m_pc;
    return r;
  endfunction

  task automatic finish_run();
    int assert_errors;
    assert_errors = DUT.u_props.failures;
    $display("errors: value %0d, status %0d, other %0d, assertion %0d", value_errors,
             status_errors, other_errors, assert_errors);
    if (value_errors + status_errors + other_errors + assert_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s", what);
    other_errors++;
    finish_run();
  endtask

  task automatic check_retire(input retire_t exp, input retire_t got);
    if (got !== exp) begin
      $display("** Error retire: expected %h, got %h", exp, got);
      value_errors++;
    end
  endtask

  task automatic check_status(input logic [`CORE_DATA_W-1:0] exp,
                              input logic [`CORE_DATA_W-1:0] got);
    if (got !== exp) begin
      $display("** Error status: expected %h, got %h", exp, got);
      status_errors++;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy !== 1'b0 && n <= WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (n > WAIT_LIMIT) begin
      stop_on_timeout("core stayed busy");
    end
  endtask

  // optionally follows up with a strobe while busy, which must be dropped
  task automatic issue(input instr_t ins, input logic stray);
    retire_t     exp;
    logic [31:0] r;
    wait_idle();
    exp = model_step(ins);
    exp_q.push_back(exp);
    issued++;
    instr       = ins;
    instr_valid = 1'b1;
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    if (stray) begin
      if (busy !== 1'b1) begin
        $display("busy was not raised after an accepted instruction");
        other_errors++;
      end
      r           = next_random();
      instr       = build_instr(OP_INC, r[1:0], r[3:2], r[4], r[15:8]);
      instr_valid = 1'b1;
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
    end
  endtask

  initial begin : compare
    int      idle;
    retire_t exp;
    idle = 0;
    forever begin
      @(negedge clk);
      if (retire_valid === 1'b1) begin
        retired++;
        idle = 0;
        if (exp_q.size() == 0) begin
          $display("retire strobe without an accepted instruction, pc %h", retire.pc);
          other_errors++;
        end else begin
          exp = exp_q.pop_front();
          check_retire(exp, retire);
          check_status(exp.status, status);
        end
      end else if (exp_q.size() != 0) begin
        idle++;
        if (idle > WAIT_LIMIT) begin
          stop_on_timeout("no retire for an accepted instruction");
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    instr_t      ins;
    opcode_e     op;
    int          d;
    int          s;
    int          n;
    rng_state   = 32'h4360b20b;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    m_p         = '0;
    m_pc        = `CORE_PC_RESET;
    for (d = 0; d < `CORE_NUM_REGS; d++) begin
      m_regs[d] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // reset state, then X, Y and S read back through A
    issue(build_instr(OP_LDI, 2'd0, 2'd0, 1'b1, 8'h5a), 1'b0);
    for (s = 1; s < 4; s++) begin
      issue(build_instr(OP_TRN, 2'd0, s[1:0], 1'b0, 8'h00), 1'b0);
    end

    repeat (40) begin
      r = next_random();
      issue(build_instr(OP_LDI, r[1:0], r[1:0], 1'b1, r[15:8]), 1'b0);
      issue(build_instr(OP_LDI, r[3:2], r[3:2], 1'b1, r[23:16]), 1'b0);
      op = r[4] ? OP_ADC : OP_SBC;
      issue(build_instr(op, r[1:0], r[3:2], r[5], r[31:24]), r[6]);
    end

    repeat (40) begin
      r = next_random();
      case (r % 32'd5)
        0:       op = OP_AND;
        1:       op = OP_ORA;
        2:       op = OP_EOR;
        3:       op = OP_INC;
        default: op = OP_DEC;
      endcase
      issue(build_instr(op, r[9:8], r[11:10], r[12], r[23:16]), r[13]);
    end

    for (d = 0; d < 4; d++) begin
      for (s = 0; s < 4; s++) begin
        r = next_random();
        issue(build_instr(OP_LDI, s[1:0], s[1:0], 1'b1, r[7:0]), 1'b0);
        issue(build_instr(OP_TRN, d[1:0], s[1:0], 1'b0, 8'h00), r[8]);
        issue(build_instr(OP_ORA, d[1:0], d[1:0], 1'b1, 8'h00), 1'b0);
      end
    end

    repeat (40) begin
      r = next_random();
      issue(build_instr(OP_ADC, r[1:0], r[3:2], 1'b1, r[15:8]), 1'b0);
      issue(build_instr(OP_BRC, r[17:16], r[19:18], r[20], r[31:24]), r[21]);
    end

    // always taken, -127 per step walks pc below zero
    repeat (48) begin
      ins         = build_instr(OP_BRC, 2'd0, 2'd0, 1'b0, 8'h80);
      ins.br_mask = 8'h00;
      ins.br_pol  = 1'b1;
      issue(ins, 1'b0);
    end

    n = 0;
    while ((exp_q.size() != 0 || busy !== 1'b0) && n <= WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (n > WAIT_LIMIT) begin
      stop_on_timeout("core did not drain");
    end else begin
      repeat (4) @(posedge clk);
      if (retired != issued) begin
        $display("retired %0d instructions but issued %0d", retired, issued);
        other_errors++;
      end
      finish_run();
    end
  end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/core_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/status_unit.sv
hdl/pc_unit.sv
hdl/exec_control.sv
hdl/exec_core.sv
test/exec_core_properties.sv
test/exec_core_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert --timescale 1ns/1ns
TOP      = exec_core_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
